//--- Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
RTL_TOP   ?= ex_stage
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- design/ex_alu.sv
// Integer ALU
// Add, subtract, logic ops, shifts and set-less-than, plus the
// comparison result used as the branch decision
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_alu (
  input  ex_pkg::alu_op_t operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);

  logic [4:0] shamt;
  logic       is_equal;
  logic       is_less;  // Signed

  assign shamt    = operand_b_i[4:0];
  assign is_equal = (operand_a_i == operand_b_i);
  assign is_less  = ($signed(operand_a_i) < $signed(operand_b_i));

  //////////////////////////////
  // Result
  //////////////////////////////
  always_comb begin
    case (operator_i)
      `EX_ALU_ADD: result_o = operand_a_i + operand_b_i;
      `EX_ALU_SUB: result_o = operand_a_i - operand_b_i;
      `EX_ALU_AND: result_o = operand_a_i & operand_b_i;
      `EX_ALU_OR:  result_o = operand_a_i | operand_b_i;
      `EX_ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      `EX_ALU_SLL: result_o = operand_a_i << shamt;
      `EX_ALU_SRL: result_o = operand_a_i >> shamt;
      `EX_ALU_SLT: result_o = {{(`EX_WORD_W-1){1'b0}}, is_less};
      default:     result_o = '0;
    endcase
  end

  // Branch decision
  always_comb begin
    if (operator_i == `EX_ALU_SLT) begin
      cmp_result_o = is_less;
    end else begin
      cmp_result_o = is_equal;
    end
  end

endmodule

//--- design/ex_ctrl.sv
// Execute stage controller
// Stall outputs, forwarding source decode, EX/WB pipeline register and
// the special-register write strobes on load writeback
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          alu_en_i,
  input  logic                          mult_en_i,
  input  logic                          csr_access_i,
  input  logic                          lsu_en_i,
  input  logic                          dot_spr_operand_i,
  input  logic                          regfile_we_i,
  input  ex_pkg::reg_addr_t             regfile_waddr_i,
  input  ex_pkg::wspr_ctl_t             lsu_tosprw_i,
  input  ex_pkg::aspr_ctl_t             lsu_tospra_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          lsu_err_i,
  input  logic                          wb_ready_i,
  input  logic                          branch_in_ex_i,
  output ex_pkg::fw_sel_t               fw_sel_o,
  output logic                          lsu_data_sel_o,
  output logic                          mult_capture_o,
  output logic                          wspr_we_o,
  output logic [$clog2(`EX_N_WSPR)-1:0] wspr_idx_o,
  output logic                          aspr_we_o,
  output logic [$clog2(`EX_N_ASPR)-1:0] aspr_idx_o,
  output logic                          regfile_we_wb_o,
  output ex_pkg::reg_addr_t             regfile_waddr_wb_o,
  output logic                          compute_load_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);

  logic              compute_load;
  logic              load_we;      // Load result goes to the register file
  logic              we_wb_q;
  ex_pkg::reg_addr_t waddr_wb_q;
  ex_pkg::wspr_ctl_t tosprw_wb_q;
  ex_pkg::aspr_ctl_t tospra_wb_q;
  logic              cl_wb_q;      // Compute-load in writeback

  assign compute_load = dot_spr_operand_i & mult_en_i;
  assign load_we      = regfile_we_i & ~lsu_err_i;

  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & lsu_ready_ex_i & wb_ready_i;
  // A branch resolves in EX and needs no writeback slot
  assign ex_ready_o = (lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;

  //////////////////////////////
  // Forwarding source
  //////////////////////////////
  always_comb begin
    if (compute_load)      fw_sel_o = `EX_FW_ALU;   // Mult result goes to load port
    else if (csr_access_i) fw_sel_o = `EX_FW_CSR;
    else if (mult_en_i)    fw_sel_o = `EX_FW_MULT;
    else                   fw_sel_o = `EX_FW_ALU;
  end

  assign mult_capture_o = compute_load & ex_valid_o;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_wb_q     <= 1'b0;
      tosprw_wb_q <= '0;
      tospra_wb_q <= '0;
      cl_wb_q     <= 1'b0;
    end else if (ex_valid_o) begin
      we_wb_q     <= load_we;
      tosprw_wb_q <= lsu_tosprw_i;
      tospra_wb_q <= lsu_tospra_i;
      cl_wb_q     <= compute_load;
    end else if (wb_ready_i) begin
      we_wb_q     <= 1'b0;  // Bubble
      cl_wb_q     <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && load_we) begin
      waddr_wb_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = we_wb_q;
  assign regfile_waddr_wb_o = waddr_wb_q;
  assign lsu_data_sel_o     = cl_wb_q;
  assign compute_load_o     = compute_load;

  // Spr loads only on a real writeback
  assign wspr_we_o  = we_wb_q & tosprw_wb_q[0];
  assign wspr_idx_o = tosprw_wb_q[$clog2(`EX_N_WSPR):1];
  assign aspr_we_o  = we_wb_q & tospra_wb_q[0];
  assign aspr_idx_o = tospra_wb_q[$clog2(`EX_N_ASPR):1];

endmodule

//--- design/ex_defines.svh
// Execute stage constants
// Data and address widths, ALU and multiplier operation codes,
// register counts and forwarding source select codes
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

`define EX_WORD_W     32
`define EX_RADDR_W    6

`define EX_ALU_OP_W   4
`define EX_ALU_ADD    4'd0
`define EX_ALU_SUB    4'd1
`define EX_ALU_AND    4'd2
`define EX_ALU_OR     4'd3
`define EX_ALU_XOR    4'd4
`define EX_ALU_SLL    4'd5
`define EX_ALU_SRL    4'd6
`define EX_ALU_SLT    4'd7

`define EX_MULT_OP_W  2
`define EX_MULT_MUL   2'd0
`define EX_MULT_DOT8  2'd1
`define EX_MULT_DOT16 2'd2

`define EX_N_WSPR     4  // Weight registers
`define EX_N_ASPR     2  // Activation registers

`define EX_FW_SEL_W   2
`define EX_FW_ALU     2'd0
`define EX_FW_MULT    2'd1
`define EX_FW_CSR     2'd2

`endif

//--- design/ex_dotp_mult.sv
// Multiplier and lane dot-product unit
// 32-bit multiply (low word) and signed DOT8 / DOT16 with accumulate
// on op C, all in a single cycle
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_dotp_mult (
  input  ex_pkg::mult_op_t operator_i,
  input  ex_pkg::word_t    op_a_i,
  input  ex_pkg::word_t    op_b_i,
  input  ex_pkg::word_t    op_c_i,
  input  ex_pkg::word_t    dot_op_a_i,
  input  ex_pkg::word_t    dot_op_b_i,
  output ex_pkg::word_t    result_o
);

  logic signed [15:0] prod8  [4];  // Byte lane products
  logic signed [31:0] prod16 [2];  // Halfword lane products
  ex_pkg::word_t      dot8_sum;
  ex_pkg::word_t      dot16_sum;
  ex_pkg::word_t      mul_lo;

  assign mul_lo = op_a_i * op_b_i;

  //////////////////////////////
  // Lane products
  //////////////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      prod8[i] = $signed(dot_op_a_i[8*i +: 8]) * $signed(dot_op_b_i[8*i +: 8]);
    end
    for (int i = 0; i < 2; i++) begin
      prod16[i] = $signed(dot_op_a_i[16*i +: 16]) * $signed(dot_op_b_i[16*i +: 16]);
    end
  end

  // Accumulate on op C
  always_comb begin
    dot8_sum = op_c_i;
    for (int i = 0; i < 4; i++) begin
      dot8_sum = dot8_sum + {{16{prod8[i][15]}}, prod8[i]};
    end
    dot16_sum = op_c_i + prod16[0] + prod16[1];
  end

  always_comb begin
    case (operator_i)
      `EX_MULT_MUL:   result_o = mul_lo;
      `EX_MULT_DOT8:  result_o = dot8_sum;
      `EX_MULT_DOT16: result_o = dot16_sum;
      default:        result_o = '0;
    endcase
  end

endmodule

//--- design/ex_pkg.sv
// Execute stage types
// Vector typedefs for data words, register addresses, operation codes,
// special-register load controls and the forwarding select
`include "ex_defines.svh"

package ex_pkg;

  typedef logic [`EX_WORD_W-1:0]    word_t;
  typedef logic [`EX_RADDR_W-1:0]   reg_addr_t;

  typedef logic [`EX_ALU_OP_W-1:0]  alu_op_t;
  typedef logic [`EX_MULT_OP_W-1:0] mult_op_t;

  //////////////////////////////
  // Special register load controls
  //////////////////////////////

  // Bit 0 enable, upper bits index
  typedef logic [$clog2(`EX_N_WSPR):0] wspr_ctl_t;
  typedef logic [$clog2(`EX_N_ASPR):0] aspr_ctl_t;

  // Source of the ALU forwarding port
  typedef logic [`EX_FW_SEL_W-1:0]  fw_sel_t;

endpackage

//--- design/ex_spr_file.sv
// Special-purpose register file for the recurrent extension
// Four weight and two activation registers loaded from memory read data,
// optionally replacing the dot-product operands
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_spr_file (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wspr_we_i,
  input  logic [$clog2(`EX_N_WSPR)-1:0] wspr_idx_i,
  input  logic                          aspr_we_i,
  input  logic [$clog2(`EX_N_ASPR)-1:0] aspr_idx_i,
  input  ex_pkg::word_t                 wdata_i,
  input  logic                          spr_sel_i,
  input  logic [$clog2(`EX_N_WSPR)-1:0] wspr_rd_idx_i,
  input  logic [$clog2(`EX_N_ASPR)-1:0] aspr_rd_idx_i,
  input  ex_pkg::word_t                 dot_op_a_i,
  input  ex_pkg::word_t                 dot_op_b_i,
  output ex_pkg::word_t                 dot_op_a_o,
  output ex_pkg::word_t                 dot_op_b_o
);

  ex_pkg::word_t wspr_q [`EX_N_WSPR];
  ex_pkg::word_t aspr_q [`EX_N_ASPR];

  //////////////////////////////
  // Register banks
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `EX_N_WSPR; i++) begin
        wspr_q[i] <= '0;
      end
    end else if (wspr_we_i) begin
      wspr_q[wspr_idx_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `EX_N_ASPR; i++) begin
        aspr_q[i] <= '0;
      end
    end else if (aspr_we_i) begin
      aspr_q[aspr_idx_i] <= wdata_i;
    end
  end

  // A takes the activation, B the weight
  assign dot_op_a_o = spr_sel_i ? aspr_q[aspr_rd_idx_i] : dot_op_a_i;
  assign dot_op_b_o = spr_sel_i ? wspr_q[wspr_rd_idx_i] : dot_op_b_i;

endmodule

//--- design/ex_stage.sv
// Execute stage top level
// ALU, multiplier with dot products, special registers for the
// recurrent extension, writeback muxes and stall control
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::alu_op_t   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,
  input  logic              alu_en_i,
  input  ex_pkg::mult_op_t  mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,
  input  ex_pkg::word_t     mult_operand_c_i,
  input  ex_pkg::word_t     mult_dot_op_a_i,
  input  ex_pkg::word_t     mult_dot_op_b_i,
  input  logic              mult_en_i,
  input  logic              dot_spr_operand_i,
  input  ex_pkg::wspr_ctl_t lsu_tosprw_i,
  input  ex_pkg::aspr_ctl_t lsu_tospra_i,
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              lsu_en_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              branch_in_ex_i,
  input  logic              wb_ready_i,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,
  output logic              compute_load_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_pkg::word_t                 alu_result;
  ex_pkg::word_t                 mult_result;
  ex_pkg::word_t                 dot_op_a;  // After spr select
  ex_pkg::word_t                 dot_op_b;
  ex_pkg::fw_sel_t               fw_sel;
  logic                          lsu_data_sel;
  logic                          mult_capture;
  logic                          wspr_we;
  logic [$clog2(`EX_N_WSPR)-1:0] wspr_idx;
  logic                          aspr_we;
  logic [$clog2(`EX_N_ASPR)-1:0] aspr_idx;

  // Straight through to ID and IF
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign jump_target_o          = alu_operand_c_i;

  ex_ctrl i_ex_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_en_i          (alu_en_i),
    .mult_en_i         (mult_en_i),
    .csr_access_i      (csr_access_i),
    .lsu_en_i          (lsu_en_i),
    .dot_spr_operand_i (dot_spr_operand_i),
    .regfile_we_i      (regfile_we_i),
    .regfile_waddr_i   (regfile_waddr_i),
    .lsu_tosprw_i      (lsu_tosprw_i),
    .lsu_tospra_i      (lsu_tospra_i),
    .lsu_ready_ex_i    (lsu_ready_ex_i),
    .lsu_err_i         (lsu_err_i),
    .wb_ready_i        (wb_ready_i),
    .branch_in_ex_i    (branch_in_ex_i),
    .fw_sel_o          (fw_sel),
    .lsu_data_sel_o    (lsu_data_sel),
    .mult_capture_o    (mult_capture),
    .wspr_we_o         (wspr_we),
    .wspr_idx_o        (wspr_idx),
    .aspr_we_o         (aspr_we),
    .aspr_idx_o        (aspr_idx),
    .regfile_we_wb_o   (regfile_we_wb_o),
    .regfile_waddr_wb_o(regfile_waddr_wb_o),
    .compute_load_o    (compute_load_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////
  ex_alu i_ex_alu (
    .operator_i  (alu_operator_i),
    .operand_a_i (alu_operand_a_i),
    .operand_b_i (alu_operand_b_i),
    .result_o    (alu_result),
    .cmp_result_o(branch_decision_o)
  );

  // Read indices come from the current instruction
  ex_spr_file i_ex_spr_file (
    .clk          (clk),
    .rst_n        (rst_n),
    .wspr_we_i    (wspr_we),
    .wspr_idx_i   (wspr_idx),
    .aspr_we_i    (aspr_we),
    .aspr_idx_i   (aspr_idx),
    .wdata_i      (lsu_rdata_i),
    .spr_sel_i    (dot_spr_operand_i),
    .wspr_rd_idx_i(lsu_tosprw_i[$clog2(`EX_N_WSPR):1]),
    .aspr_rd_idx_i(lsu_tospra_i[$clog2(`EX_N_ASPR):1]),
    .dot_op_a_i   (mult_dot_op_a_i),
    .dot_op_b_i   (mult_dot_op_b_i),
    .dot_op_a_o   (dot_op_a),
    .dot_op_b_o   (dot_op_b)
  );

  ex_dotp_mult i_ex_dotp_mult (
    .operator_i(mult_operator_i),
    .op_a_i    (mult_operand_a_i),
    .op_b_i    (mult_operand_b_i),
    .op_c_i    (mult_operand_c_i),
    .dot_op_a_i(dot_op_a),
    .dot_op_b_i(dot_op_b),
    .result_o  (mult_result)
  );

  ex_wb_mux i_ex_wb_mux (
    .clk           (clk),
    .rst_n         (rst_n),
    .fw_sel_i      (fw_sel),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .csr_rdata_i   (csr_rdata_i),
    .mult_capture_i(mult_capture),
    .lsu_data_sel_i(lsu_data_sel),
    .lsu_rdata_i   (lsu_rdata_i),
    .fw_wdata_o    (regfile_alu_wdata_fw_o),
    .wb_wdata_o    (regfile_wdata_wb_o)
  );

endmodule

//--- design/ex_wb_mux.sv
// Writeback data muxes
// Forwarding port data select and load port data, which carries the
// delayed multiplier result after a compute-load
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_wb_mux (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::fw_sel_t fw_sel_i,
  input  ex_pkg::word_t   alu_result_i,
  input  ex_pkg::word_t   mult_result_i,
  input  ex_pkg::word_t   csr_rdata_i,
  input  logic            mult_capture_i,
  input  logic            lsu_data_sel_i,
  input  ex_pkg::word_t   lsu_rdata_i,
  output ex_pkg::word_t   fw_wdata_o,
  output ex_pkg::word_t   wb_wdata_o
);

  ex_pkg::word_t mult_result_q;

  //////////////////////////////
  // Forwarding port
  //////////////////////////////
  always_comb begin
    case (fw_sel_i)
      `EX_FW_MULT: fw_wdata_o = mult_result_i;
      `EX_FW_CSR:  fw_wdata_o = csr_rdata_i;
      default:     fw_wdata_o = alu_result_i;
    endcase
  end

  // Delayed dot product for the load port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mult_result_q <= '0;
    end else if (mult_capture_i) begin
      mult_result_q <= mult_result_i;
    end
  end

  assign wb_wdata_o = lsu_data_sel_i ? mult_result_q : lsu_rdata_i;

endmodule

//--- sim.f
+incdir+design
design/ex_pkg.sv
design/ex_alu.sv
design/ex_dotp_mult.sv
design/ex_spr_file.sv
design/ex_ctrl.sv
design/ex_wb_mux.sv
design/ex_stage.sv
tb/tb_ex_stage.sv

//--- tb/ex_stimulus.txt
# I tag aop aa ab ac aen mop ma mb mc da db men dspr sprw spra csr csrd awe awad we wad
#   len lrdy lerr lrd br wbr  /  E mask fwe fwa fwd wewb wawb wdwb jmp br cl rdy vld (hex)
# After reset, special registers read zero through a compute-load DOT8
I rst 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1
E 6ac 0 0 0 0 0 0 0 1 0 1 0
I spr0 0 0 0 0 0 1 0 0 0 ffffffff ffffffff 1 1 0 0 0 0 0 0 0 0 0 1 0 0 0 1
E 504 0 0 0 0 0 0 0 0 1 0 1
I spr0_wb 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 ffffffff 0 1
E 28 0 0 0 0 0 0 0 0 0 0 0
# ALU operations on the forwarding port
I add 0 10 20 100 1 0 0 0 0 0 0 0 0 0 0 0 0 1 5 0 0 0 1 0 0 0 1
E 7c7 1 5 30 0 0 0 100 0 0 1 1
I sub 1 50 50 104 1 0 0 0 0 0 0 0 0 0 0 0 0 1 6 0 0 0 1 0 0 0 1
E 7c7 1 6 0 0 0 0 104 1 0 1 1
I and 2 f0f0 ff00 108 1 0 0 0 0 0 0 0 0 0 0 0 0 0 7 0 0 0 1 0 0 0 1
E 7c7 0 7 f000 0 0 0 108 0 0 1 1
I or 3 f0f0 f0f 10c 1 0 0 0 0 0 0 0 0 0 0 0 0 1 8 0 0 0 1 0 0 0 1
E 7c7 1 8 ffff 0 0 0 10c 0 0 1 1
I xor 4 ffff ff 110 1 0 0 0 0 0 0 0 0 0 0 0 0 1 9 0 0 0 1 0 0 0 1
E 7c7 1 9 ff00 0 0 0 110 0 0 1 1
I sll 5 1 24 114 1 0 0 0 0 0 0 0 0 0 0 0 0 1 a 0 0 0 1 0 0 0 1
E 7c7 1 a 10 0 0 0 114 0 0 1 1
I srl 6 80000000 1f 118 1 0 0 0 0 0 0 0 0 0 0 0 0 1 b 0 0 0 1 0 0 0 1
E 7c7 1 b 1 0 0 0 118 0 0 1 1
I slt 7 ffffffff 1 11c 1 0 0 0 0 0 0 0 0 0 0 0 0 1 c 0 0 0 1 0 0 0 1
E 7c7 1 c 1 0 0 0 11c 1 0 1 1
# Multiplier with register operands, CSR overrides
I mul 0 0 0 0 0 0 1234 10 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1
E 504 0 0 12340 0 0 0 0 0 0 0 1
I dot8 0 0 0 0 0 1 0 0 10 fe020304 5060708 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1
E 504 0 0 47 0 0 0 0 0 0 0 1
I dot16 0 0 0 0 0 2 0 0 100 3fffe 40005 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1
E 504 0 0 102 0 0 0 0 0 0 0 1
I csr 0 1 1 0 1 0 2 3 0 0 0 1 0 0 0 1 cafe 0 0 0 0 0 1 0 0 0 1
E 504 0 0 cafe 0 0 0 0 0 0 0 1
# Load writeback and a load with an error
I ld 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 a 1 1 0 0 0 1
E 400 0 0 0 0 0 0 0 0 0 0 1
I ld_wb 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 deadbeef 0 1
E 38 0 0 0 1 a deadbeef 0 0 0 0 0
I ld_err 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 b 1 1 1 0 0 1
E 8 0 0 0 0 0 0 0 0 0 0 0
I ld_err_wb 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 12345678 0 1
E 8 0 0 0 0 0 0 0 0 0 0 0
# Special-register loads into weight 2 and activation 1
I spr_ld_w 0 0 0 0 0 0 0 0 0 0 0 0 0 5 0 0 0 0 0 1 1 1 1 0 0 0 1
E 400 0 0 0 0 0 0 0 0 0 0 1
I spr_ld_a 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 0 0 0 0 1 2 1 1 0 1020304 0 1
E 38 0 0 0 1 1 1020304 0 0 0 0 0
I spr_wb 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 5060708 0 1
E 38 0 0 0 1 2 5060708 0 0 0 0 0
I spr_nocl 0 3 4 0 1 1 0 0 10 0 0 0 1 4 2 0 0 0 0 0 0 0 1 0 0 0 1
E 504 0 0 7 0 0 0 0 0 0 0 1
# Compute-load pairing, result one cycle later on the load port
I cl 0 3 4 0 1 1 0 0 10 ffffffff ffffffff 1 1 4 2 0 0 0 0 1 7 0 1 0 0 0 1
E 504 0 0 7 0 0 0 0 0 1 0 1
I cl_wb 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 11111111 0 1
E 138 0 0 0 1 7 56 0 0 0 0 0
# Back-pressure from writeback
I bp_ld 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 3 1 1 0 0 0 1
E 400 0 0 0 0 0 0 0 0 0 0 1
I bp_stall 0 1 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0
E 608 0 0 0 1 0 0 0 0 0 0 0
I bp_br 0 1 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0
E 608 0 0 0 1 0 0 0 0 0 1 0
I bp_resume 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1
E 208 0 0 0 1 0 0 0 0 0 1 0
I bp_done 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1
E 8 0 0 0 0 0 0 0 0 0 0 0

//--- tb/tb_ex_stage.sv
// Testbench for the execute stage
// Reads one cycle per vector pair from the stimulus file, drives the DUT
// on the rising edge and checks the masked outputs just before the next edge
`timescale 1ns/10ps

module tb_ex_stage;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 16;

  logic              clk;
  logic              rst_n;
  ex_pkg::alu_op_t   alu_operator;
  ex_pkg::word_t     alu_operand_a, alu_operand_b, alu_operand_c;
  logic              alu_en;
  ex_pkg::mult_op_t  mult_operator;
  ex_pkg::word_t     mult_operand_a, mult_operand_b, mult_operand_c;
  ex_pkg::word_t     mult_dot_op_a, mult_dot_op_b;
  logic              mult_en;
  logic              dot_spr_operand;
  ex_pkg::wspr_ctl_t lsu_tosprw;
  ex_pkg::aspr_ctl_t lsu_tospra;
  logic              csr_access;
  ex_pkg::word_t     csr_rdata;
  logic              regfile_alu_we;
  ex_pkg::reg_addr_t regfile_alu_waddr;
  logic              regfile_we;
  ex_pkg::reg_addr_t regfile_waddr;
  logic              lsu_en, lsu_ready_ex, lsu_err;
  ex_pkg::word_t     lsu_rdata;
  logic              branch_in_ex, wb_ready;

  logic              regfile_alu_we_fw;
  ex_pkg::reg_addr_t regfile_alu_waddr_fw;
  ex_pkg::word_t     regfile_alu_wdata_fw;
  logic              regfile_we_wb;
  ex_pkg::reg_addr_t regfile_waddr_wb;
  ex_pkg::word_t     regfile_wdata_wb;
  ex_pkg::word_t     jump_target;
  logic              branch_decision, compute_load, ex_ready, ex_valid;

  string             in_lines[$];
  string             exp_lines[$];
  string             cur_tag;
  bit                vectors_loaded;

  ex_stage i_ex_stage (
    .clk(clk), .rst_n(rst_n),
    .alu_operator_i(alu_operator), .alu_operand_a_i(alu_operand_a),
    .alu_operand_b_i(alu_operand_b), .alu_operand_c_i(alu_operand_c),
    .alu_en_i(alu_en), .mult_operator_i(mult_operator),
    .mult_operand_a_i(mult_operand_a), .mult_operand_b_i(mult_operand_b),
    .mult_operand_c_i(mult_operand_c), .mult_dot_op_a_i(mult_dot_op_a),
    .mult_dot_op_b_i(mult_dot_op_b), .mult_en_i(mult_en),
    .dot_spr_operand_i(dot_spr_operand), .lsu_tosprw_i(lsu_tosprw),
    .lsu_tospra_i(lsu_tospra), .csr_access_i(csr_access), .csr_rdata_i(csr_rdata),
    .regfile_alu_we_i(regfile_alu_we), .regfile_alu_waddr_i(regfile_alu_waddr),
    .regfile_we_i(regfile_we), .regfile_waddr_i(regfile_waddr),
    .lsu_en_i(lsu_en), .lsu_ready_ex_i(lsu_ready_ex), .lsu_err_i(lsu_err),
    .lsu_rdata_i(lsu_rdata), .branch_in_ex_i(branch_in_ex), .wb_ready_i(wb_ready),
    .regfile_alu_we_fw_o(regfile_alu_we_fw), .regfile_alu_waddr_fw_o(regfile_alu_waddr_fw),
    .regfile_alu_wdata_fw_o(regfile_alu_wdata_fw), .regfile_we_wb_o(regfile_we_wb),
    .regfile_waddr_wb_o(regfile_waddr_wb), .regfile_wdata_wb_o(regfile_wdata_wb),
    .jump_target_o(jump_target), .branch_decision_o(branch_decision),
    .compute_load_o(compute_load), .ex_ready_o(ex_ready), .ex_valid_o(ex_valid)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_word(input string name, input ex_pkg::word_t exp_v,
                            input ex_pkg::word_t act_v);
    if (act_v !== exp_v) begin
      $display("Error at %0d ns: %s in vector %s expected %h got %h",
               $time, name, cur_tag, exp_v, act_v);
      $display("Testbench failed");
      $fatal(1, "Word mismatch");
    end
  endtask

  task automatic check_addr(input string name, input ex_pkg::reg_addr_t exp_v,
                            input ex_pkg::reg_addr_t act_v);
    if (act_v !== exp_v) begin
      $display("Error at %0d ns: %s in vector %s expected %h got %h",
               $time, name, cur_tag, exp_v, act_v);
      $display("Testbench failed");
      $fatal(1, "Address mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("Error at %0d ns: %s in vector %s expected %b got %b",
               $time, name, cur_tag, exp_v, act_v);
      $display("Testbench failed");
      $fatal(1, "Bit mismatch");
    end
  endtask

  task automatic report_bad_line(input string line);
    $display("Malformed stimulus line: %s", line);
    $display("Testbench failed");
    $fatal(1, "Bad stimulus file");
  endtask

  //////////////////////////////
  // Vector handling
  //////////////////////////////
  task automatic drive_vector(input string line);
    string             tag;
    ex_pkg::alu_op_t   aop;
    ex_pkg::word_t     aa, ab, ac, ma, mb, mc, da, db, csrd, lrd;
    ex_pkg::mult_op_t  mop;
    ex_pkg::wspr_ctl_t sprw;
    ex_pkg::aspr_ctl_t spra;
    ex_pkg::reg_addr_t awad, wad;
    logic              aen, men, dspr, csr, awe, we, len, lrdy, lerr, br, wbr;
    int                n;
    n = $sscanf(line,
      "I %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
      tag, aop, aa, ab, ac, aen, mop, ma, mb, mc, da, db, men, dspr, sprw, spra,
      csr, csrd, awe, awad, we, wad, len, lrdy, lerr, lrd, br, wbr);
    if (n != 28) report_bad_line(line);
    cur_tag           = tag;
    alu_operator      <= aop;
    alu_operand_a     <= aa;
    alu_operand_b     <= ab;
    alu_operand_c     <= ac;
    alu_en            <= aen;
    mult_operator     <= mop;
    mult_operand_a    <= ma;
    mult_operand_b    <= mb;
    mult_operand_c    <= mc;
    mult_dot_op_a     <= da;
    mult_dot_op_b     <= db;
    mult_en           <= men;
    dot_spr_operand   <= dspr;
    lsu_tosprw        <= sprw;
    lsu_tospra        <= spra;
    csr_access        <= csr;
    csr_rdata         <= csrd;
    regfile_alu_we    <= awe;
    regfile_alu_waddr <= awad;
    regfile_we        <= we;
    regfile_waddr     <= wad;
    lsu_en            <= len;
    lsu_ready_ex      <= lrdy;
    lsu_err           <= lerr;
    lsu_rdata         <= lrd;
    branch_in_ex      <= br;
    wb_ready          <= wbr;
  endtask

  task automatic check_vector(input string line);
    logic [10:0]       mask;  // One bit per output column
    logic              fwe, wewb, brd, cl, rdy, vld;
    ex_pkg::reg_addr_t fwa, wawb;
    ex_pkg::word_t     fwd, wdwb, jmp;
    int                n;
    n = $sscanf(line, "E %h %h %h %h %h %h %h %h %h %h %h %h",
                mask, fwe, fwa, fwd, wewb, wawb, wdwb, jmp, brd, cl, rdy, vld);
    if (n != 12) report_bad_line(line);
    if (mask[0])  check_bit("regfile_alu_we_fw_o", fwe, regfile_alu_we_fw);
    if (mask[1])  check_addr("regfile_alu_waddr_fw_o", fwa, regfile_alu_waddr_fw);
    if (mask[2])  check_word("regfile_alu_wdata_fw_o", fwd, regfile_alu_wdata_fw);
    if (mask[3])  check_bit("regfile_we_wb_o", wewb, regfile_we_wb);
    if (mask[4])  check_addr("regfile_waddr_wb_o", wawb, regfile_waddr_wb);
    if (mask[5])  check_word("regfile_wdata_wb_o", wdwb, regfile_wdata_wb);
    if (mask[6])  check_word("jump_target_o", jmp, jump_target);
    if (mask[7])  check_bit("branch_decision_o", brd, branch_decision);
    if (mask[8])  check_bit("compute_load_o", cl, compute_load);
    if (mask[9])  check_bit("ex_ready_o", rdy, ex_ready);
    if (mask[10]) check_bit("ex_valid_o", vld, ex_valid);
  endtask

  task automatic load_vectors();
    int    fd;
    string line;
    fd = $fopen("tb/ex_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb/ex_stimulus.txt");
      $display("Testbench failed");
      $fatal(1, "Missing stimulus file");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] == "I") in_lines.push_back(line);
        else if (line.len() > 0 && line[0] == "E") exp_lines.push_back(line);
      end
    end
    $fclose(fd);
    if (in_lines.size() == 0 || in_lines.size() != exp_lines.size()) begin
      $display("Stimulus file has no vectors or unpaired input and expected lines");
      $display("Testbench failed");
      $fatal(1, "Bad stimulus file");
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    clk               = 1'b0;
    rst_n             = 1'b0;
    alu_operator      = '0;
    alu_operand_a     = '0;
    alu_operand_b     = '0;
    alu_operand_c     = '0;
    alu_en            = 1'b0;
    mult_operator     = '0;
    mult_operand_a    = '0;
    mult_operand_b    = '0;
    mult_operand_c    = '0;
    mult_dot_op_a     = '0;
    mult_dot_op_b     = '0;
    mult_en           = 1'b0;
    dot_spr_operand   = 1'b0;
    lsu_tosprw        = '0;
    lsu_tospra        = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    lsu_en            = 1'b0;
    lsu_ready_ex      = 1'b1;
    lsu_err           = 1'b0;
    lsu_rdata         = '0;
    branch_in_ex      = 1'b0;
    wb_ready          = 1'b1;
    vectors_loaded    = 1'b0;
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    foreach (in_lines[i]) begin
      @(posedge clk);
      drive_vector(in_lines[i]);
      #(CLK_PERIOD - 1);  // Just before the next edge
      check_vector(exp_lines[i]);
    end
    $display("Testbench passed");
    $finish;
  end

  // Watchdog at twice the reset and vector time
  initial begin
    wait (vectors_loaded);
    #((in_lines.size() * CLK_PERIOD + RST_CYCLES * CLK_PERIOD) * 2);
    $display("Timeout: the vectors did not finish in time");
    $display("Testbench failed");
    $fatal(1, "Watchdog expired");
  end

endmodule
